//--- files.f
hw/maxpool_pkg.sv
hw/pool_member_counter.sv
hw/pool_row_fsm.sv
hw/pool_compare_buffer.sv
hw/pool_output_select.sv
hw/maxpool_engine.sv
verif/maxpool_tb.sv

//--- hw/maxpool_engine.sv
// Top level of the 2x2 max-pooling engine joining counter, FSM, compare buffer and output select
`timescale 1ns/10ps

module maxpool_engine (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    s_valid,
  output logic                    s_ready,
  input  maxpool_pkg::pool_beat_t s_data,
  input  maxpool_pkg::pool_user_t s_user,
  output logic                    m_valid,        // No back-pressure on the output
  output maxpool_pkg::pool_beat_t m_data,
  output maxpool_pkg::pool_keep_t m_keep,
  output logic                    m_last
);

  logic                                handshake;       // Beat transfer this edge
  logic [maxpool_pkg::MEMBER_BITS-1:0] count;
  logic                                wrap;
  logic                                sel_max4;
  logic                                buf_shift_first;
  logic                                buf_shift_rest;
  logic                                delay_en;
  logic                                out_max_valid;
  maxpool_pkg::pool_lanes_t            pooled;

  assign handshake = s_valid && s_ready;                // Shared by every block

  pool_member_counter pool_member_counter_inst (
    .clk       (clk),
    .rst       (rst),
    .handshake (handshake),
    .count     (count),
    .wrap      (wrap)
  );

  pool_row_fsm pool_row_fsm_inst (
    .clk             (clk),
    .rst             (rst),
    .handshake       (handshake),
    .wrap            (wrap),
    .count           (count),
    .s_user          (s_user),
    .state           (),
    .s_ready         (s_ready),
    .sel_max4        (sel_max4),
    .buf_shift_first (buf_shift_first),
    .buf_shift_rest  (buf_shift_rest),
    .delay_en        (delay_en),
    .m_valid         (m_valid),
    .m_last          (m_last),
    .out_max_valid   (out_max_valid)
  );

  pool_compare_buffer pool_compare_buffer_inst (
    .clk             (clk),
    .rst             (rst),
    .s_data          (s_data),
    .sel_max4        (sel_max4),
    .buf_shift_first (buf_shift_first),
    .buf_shift_rest  (buf_shift_rest),
    .pooled          (pooled)
  );

  pool_output_select pool_output_select_inst (
    .clk           (clk),
    .rst           (rst),
    .s_data        (s_data),
    .delay_en      (delay_en),
    .out_max_valid (out_max_valid),
    .pooled        (pooled),
    .m_data        (m_data),
    .m_keep        (m_keep)
  );

endmodule

//--- hw/maxpool_pkg.sv
// Sizes, row state enum, user field, lane, beat and keep structs for the max-pooling engine

package maxpool_pkg;

  // Array geometry
  localparam int UNITS       = 4;                     // Lanes per group
  localparam int GROUPS      = 2;                     // Groups per beat
  localparam int MEMBERS     = 4;                     // Beats per pooling row
  localparam int WORD_WIDTH  = 8;                     // Signed pixel width
  localparam int LANES       = GROUPS * UNITS;        // Words per column slot
  localparam int MEMBER_BITS = $clog2(MEMBERS);       // Width of the member count

  // Row state
  // MAX_2_S covers pass-through and the first row of a max packet,
  // MAX_4_S the second row where the 2x2 maximum is formed
  typedef enum logic {
    MAX_2_S = 1'b0,                                   // First row or pass-through
    MAX_4_S = 1'b1                                    // Second row, vertical compare
  } pool_state_e;

  // Per-packet mode, constant for the whole packet
  typedef struct packed {
    logic is_max;                                     // Produce 2x2 maxima
    logic is_not_max;                                 // Produce pass-through beats
  } pool_user_t;

  // One signed pixel
  typedef logic signed [WORD_WIDTH-1:0] pool_word_t;

  // One column slot across all lanes, lane 0 in the low bits
  typedef pool_word_t [LANES-1:0] pool_lanes_t;

  // Two horizontally adjacent pixels per lane
  typedef struct packed {
    pool_lanes_t col1;                                // Right pixel of the pair
    pool_lanes_t col0;                                // Left pixel, carries maxima on output
  } pool_beat_t;

  // Byte-lane style keep, one bit per word
  typedef struct packed {
    logic [LANES-1:0] col1;                           // Cleared on pooled beats
    logic [LANES-1:0] col0;                           // Always kept
  } pool_keep_t;

endpackage

//--- hw/pool_compare_buffer.sv
// Per-lane signed comparators, compare input muxes and the line buffer shift chain
`timescale 1ns/10ps

module pool_compare_buffer (
  input  logic                     clk,
  input  logic                     rst,
  input  maxpool_pkg::pool_beat_t  s_data,
  input  logic                     sel_max4,        // Compare buffered rows
  input  logic                     buf_shift_first, // Load entry 1
  input  logic                     buf_shift_rest,  // Shift entries 2 and up
  output maxpool_pkg::pool_lanes_t pooled           // Newest buffer entry
);

  localparam int DEPTH = maxpool_pkg::MEMBERS + 1;  // One row plus the current beat

  maxpool_pkg::pool_lanes_t cmp_a;                  // Left comparator inputs
  maxpool_pkg::pool_lanes_t cmp_b;                  // Right comparator inputs
  maxpool_pkg::pool_lanes_t max_out;                // Comparator results
  maxpool_pkg::pool_lanes_t buf_q [1:DEPTH];        // Entry 1 newest, DEPTH oldest

  // Horizontal pair normally, second-row result against first-row entry in the compare cycle
  assign cmp_a = sel_max4 ? buf_q[1]     : s_data.col0;
  assign cmp_b = sel_max4 ? buf_q[DEPTH] : s_data.col1;

  // One signed comparator per lane
  for (genvar l = 0; l < maxpool_pkg::LANES; l++) begin : g_lane
    maxpool_pkg::pool_word_t a;
    maxpool_pkg::pool_word_t b;

    assign a = cmp_a[l];
    assign b = cmp_b[l];
    assign max_out[l] = ($signed(a) > $signed(b)) ? a : b;  // Ties pick right value
  end

  // Shift chain
  // After a full first row, entry DEPTH lines up with the second-row beat
  // just written into entry 1, so every compare sees the matching position
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int m = 1; m <= DEPTH; m++) begin
        buf_q[m] <= '0;
      end
    end else begin
      if (buf_shift_first) begin
        buf_q[1] <= max_out;                        // Horizontal max, then 2x2 max
      end
      if (buf_shift_rest) begin
        for (int m = 2; m <= DEPTH; m++) begin
          buf_q[m] <= buf_q[m-1];                   // Age one position per beat
        end
      end
    end
  end

  assign pooled = buf_q[1];                         // Holds the 2x2 max after the compare cycle

endmodule

//--- hw/pool_member_counter.sv
// Modulo-MEMBERS counter of input handshakes with a row-end wrap flag
`timescale 1ns/10ps

module pool_member_counter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                handshake,  // Input beat accepted
  output logic [maxpool_pkg::MEMBER_BITS-1:0] count,      // Beat position within row
  output logic                                wrap        // Last beat of row accepted
);

  localparam logic [maxpool_pkg::MEMBER_BITS-1:0] LAST_MEMBER =
    maxpool_pkg::MEMBER_BITS'(maxpool_pkg::MEMBERS - 1);

  logic at_last;                                          // Count sits on final position
  logic [maxpool_pkg::MEMBER_BITS-1:0] count_next;

  assign at_last = (count == LAST_MEMBER);
  assign wrap    = handshake && at_last;                  // Qualified by the transfer

  // Roll back to zero at the row end, MEMBERS need not be a power of two
  assign count_next = at_last ? '0 : count + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;                                        // Start of a row
    end else if (handshake) begin
      count <= count_next;                                // Only accepted beats count
    end
  end

endmodule

//--- hw/pool_output_select.sv
// Pass-through delay register, output data mux and keep generation
`timescale 1ns/10ps

module pool_output_select (
  input  logic                     clk,
  input  logic                     rst,
  input  maxpool_pkg::pool_beat_t  s_data,
  input  logic                     delay_en,       // Capture the accepted beat
  input  logic                     out_max_valid,  // Pooled beat selected
  input  maxpool_pkg::pool_lanes_t pooled,
  output maxpool_pkg::pool_beat_t  m_data,
  output maxpool_pkg::pool_keep_t  m_keep
);

  maxpool_pkg::pool_beat_t delay_q;                // Pass-through beat, one cycle late

  always_ff @(posedge clk) begin
    if (rst) begin
      delay_q <= '0;
    end else if (delay_en) begin
      delay_q <= s_data;                           // Holds over gaps and compare cycles
    end
  end

  // Pooled maxima ride on col0
  // col1 keeps the stale delayed pixels but is marked unkept
  always_comb begin
    m_data.col0 = out_max_valid ? pooled : delay_q.col0;
    m_data.col1 = delay_q.col1;
  end

  always_comb begin
    m_keep.col0 = '1;                              // Left slot always valid
    m_keep.col1 = out_max_valid ? '0 : '1;         // Half width on pooled beats
  end

endmodule

//--- hw/pool_row_fsm.sv
// Row state machine with ready control, buffer enables, output valid and last generation
`timescale 1ns/10ps

module pool_row_fsm (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                handshake,
  input  logic                                wrap,
  input  logic [maxpool_pkg::MEMBER_BITS-1:0] count,
  input  maxpool_pkg::pool_user_t             s_user,
  output maxpool_pkg::pool_state_e            state,
  output logic                                s_ready,
  output logic                                sel_max4,        // Compare cycle flag
  output logic                                buf_shift_first, // Enable of buffer entry 1
  output logic                                buf_shift_rest,  // Enable of the other entries
  output logic                                delay_en,        // Capture pass-through beat
  output logic                                m_valid,
  output logic                                m_last,
  output logic                                out_max_valid    // Pooled beat on the output
);

  logic max4_hs;                     // Second-row beat accepted
  logic max_valid_d1;                // First stage of pooled valid
  logic out_delay_valid;             // Pass-through beat on the output
  logic both_max4;                   // Second-row beat in max and non-max mode
  logic last_pair_q;                 // Both outputs of a second-row beat end a packet

  assign max4_hs = handshake && (state == maxpool_pkg::MAX_4_S);

  // Row state toggles at each row end of a max packet
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= maxpool_pkg::MAX_2_S;
    end else if (wrap && s_user.is_max) begin
      state <= (state == maxpool_pkg::MAX_2_S) ? maxpool_pkg::MAX_4_S : maxpool_pkg::MAX_2_S;
    end
  end

  // Compare cycle follows every second-row handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_max4 <= 1'b0;
    end else begin
      sel_max4 <= max4_hs;
    end
  end

  assign s_ready = ~sel_max4;        // Comparator busy with buffered values

  // Entry 1 shifts again in the compare cycle to take the 2x2 maximum
  assign buf_shift_first = s_user.is_max && (handshake || sel_max4);
  assign buf_shift_rest  = s_user.is_max && handshake;
  assign delay_en        = s_user.is_not_max && handshake;

  // Valid pipelines, one stage for pass-through and two for pooled
  always_ff @(posedge clk) begin
    if (rst) begin
      out_delay_valid <= 1'b0;
      max_valid_d1    <= 1'b0;
      out_max_valid   <= 1'b0;
    end else begin
      out_delay_valid <= delay_en;
      max_valid_d1    <= max4_hs && s_user.is_max;
      out_max_valid   <= max_valid_d1;
    end
  end

  assign m_valid = out_max_valid || out_delay_valid;  // Never both, s_ready gap keeps them apart

  // Held until the next beat, covers the pass-through and the pooled output
  assign both_max4 = max4_hs && s_user.is_max && s_user.is_not_max;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_pair_q <= 1'b0;
    end else if (handshake) begin
      last_pair_q <= both_max4;
    end
  end

  assign m_last = m_valid && ((count == '0) || last_pair_q);  // Row end or paired beat

endmodule

//--- verif/maxpool_tb.sv
// Testbench for maxpool_engine with clock, reset, packet stimulus, reference model and assertions
`timescale 1ns/10ps

module maxpool_tb;

  localparam int PACKET_BEATS   = 2 * maxpool_pkg::MEMBERS;        // Two rows per packet
  localparam int TOTAL_PACKETS  = 17;                              // Summed over all tests
  localparam int TOTAL_BEATS    = PACKET_BEATS * TOTAL_PACKETS;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_BEATS + 200;

  localparam maxpool_pkg::pool_user_t USER_NON_MAX = 2'b01;        // is_max low, is_not_max high
  localparam maxpool_pkg::pool_user_t USER_MAX     = 2'b10;
  localparam maxpool_pkg::pool_user_t USER_BOTH    = 2'b11;

  // One expected output beat
  typedef struct packed {
    maxpool_pkg::pool_beat_t data;
    maxpool_pkg::pool_keep_t keep;
    logic                    last;
  } out_beat_t;

  logic                    clk;
  logic                    rst;
  logic                    s_valid;
  logic                    s_ready;
  maxpool_pkg::pool_beat_t s_data;
  maxpool_pkg::pool_user_t s_user;
  logic                    m_valid;
  maxpool_pkg::pool_beat_t m_data;
  maxpool_pkg::pool_keep_t m_keep;
  logic                    m_last;

  integer    seed = 32'h978e_79fa;                                 // Fixed stimulus seed
  int        err_count;
  int        tests_passed;
  int        tests_failed;
  int        test_num;
  int        cycle_count;
  out_beat_t exp_q[$];                                             // Outputs still to come, in order
  out_beat_t exp_now;                                              // Head of exp_q
  bit        exp_avail;                                            // exp_q not empty
  int        model_pos;                                            // Beat position in row
  bit        model_row2;                                           // Second row of a max packet
  maxpool_pkg::pool_beat_t first_row [maxpool_pkg::MEMBERS];       // Raw first-row beats
  logic      row2_hs;                                              // Second-row beat accepted

  maxpool_engine maxpool_engine_inst (
    .clk     (clk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .s_user  (s_user),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_keep  (m_keep),
    .m_last  (m_last)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                                        // 40 ns period
  end

  task automatic value_error(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    err_count++;
    $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
  endtask

  task automatic report_failure(input string msg);
    err_count++;
    $display("Failure at %0t ns: %s", $time, msg);
  endtask

  function automatic maxpool_pkg::pool_word_t max_of_four(input maxpool_pkg::pool_word_t a,
    input maxpool_pkg::pool_word_t b, input maxpool_pkg::pool_word_t c,
    input maxpool_pkg::pool_word_t d);
    maxpool_pkg::pool_word_t best;
    best = a;
    if (b > best) best = b;                                        // Signed compare via word type
    if (c > best) best = c;
    if (d > best) best = d;
    return best;
  endfunction

  // Reference model, one call per accepted beat
  task automatic model_accept(input maxpool_pkg::pool_beat_t beat,
                              input maxpool_pkg::pool_user_t user);
    out_beat_t               ob;
    maxpool_pkg::pool_beat_t up;
    ob = '0;
    if (user.is_not_max) begin
      ob.data = beat;
      ob.keep = '1;
      ob.last = (model_pos == maxpool_pkg::MEMBERS - 1) || (model_row2 && user.is_max);
      exp_q.push_back(ob);                                         // Pass-through first
    end
    if (user.is_max && model_row2) begin
      up      = first_row[model_pos];                              // Same position, row above
      ob.data = '0;
      for (int l = 0; l < maxpool_pkg::LANES; l++) begin
        ob.data.col0[l] = max_of_four(up.col0[l], up.col1[l], beat.col0[l], beat.col1[l]);
      end
      ob.keep.col0 = '1;
      ob.keep.col1 = '0;                                           // Half width pooled beat
      ob.last      = (model_pos == maxpool_pkg::MEMBERS - 1) || user.is_not_max;
      exp_q.push_back(ob);
    end else if (user.is_max) begin
      first_row[model_pos] = beat;
    end
    if (model_pos == maxpool_pkg::MEMBERS - 1) begin
      model_pos = 0;
      if (user.is_max) model_row2 = !model_row2;                   // Row toggle on max packets
    end else begin
      model_pos++;
    end
  endtask

  // Pops on each output, pushes on each accepted beat, pre-edge values throughout
  always @(posedge clk) begin
    if (rst) begin
      exp_q.delete();
      model_pos  = 0;
      model_row2 = 1'b0;
    end else begin
      if (m_valid && exp_q.size() > 0) void'(exp_q.pop_front());
      if (s_valid && s_ready) model_accept(s_data, s_user);
    end
    exp_avail = (exp_q.size() > 0);
    if (exp_avail) exp_now = exp_q[0];
  end

  assign row2_hs = s_valid && s_ready && model_row2;

  idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> s_ready && !m_valid)
    else report_failure("engine not idle after reset release");
  output_expected: assert property (@(posedge clk) disable iff (rst) m_valid |-> exp_avail)
    else report_failure("output beat appeared with no expected beat left");
  col0_matches: assert property (@(posedge clk) disable iff (rst)
    m_valid && exp_avail |-> m_data.col0 == exp_now.data.col0)
    else value_error("m_data.col0", $sampled(exp_now.data.col0), $sampled(m_data.col0));
  col1_matches: assert property (@(posedge clk) disable iff (rst)
    m_valid && exp_avail && exp_now.keep.col1 != '0 |-> m_data.col1 == exp_now.data.col1)
    else value_error("m_data.col1", $sampled(exp_now.data.col1), $sampled(m_data.col1));
  keep_matches: assert property (@(posedge clk) disable iff (rst)
    m_valid && exp_avail |-> m_keep == exp_now.keep)
    else value_error("m_keep", $sampled(exp_now.keep), $sampled(m_keep));
  last_matches: assert property (@(posedge clk) disable iff (rst)
    m_valid && exp_avail |-> m_last == exp_now.last)
    else value_error("m_last", $sampled(exp_now.last), $sampled(m_last));
  pass_one_cycle: assert property (@(posedge clk) disable iff (rst)
    s_valid && s_ready && s_user.is_not_max |=> m_valid)
    else report_failure("pass-through beat missing one cycle after its handshake");
  pooled_two_cycles: assert property (@(posedge clk) disable iff (rst) row2_hs |-> ##2 m_valid)
    else report_failure("pooled beat missing two cycles after a second-row handshake");
  ready_drops: assert property (@(posedge clk) disable iff (rst) row2_hs |=> !s_ready)
    else report_failure("s_ready stayed high after a second-row handshake");
  ready_low_cause: assert property (@(posedge clk) disable iff (rst) !s_ready |-> $past(row2_hs))
    else report_failure("s_ready low without a second-row handshake just before");

  task automatic make_beat(input bit negative, output maxpool_pkg::pool_beat_t beat);
    logic [31:0] rnd;
    for (int l = 0; l < maxpool_pkg::LANES; l++) begin
      rnd = $random(seed);
      beat.col0[l] = rnd[maxpool_pkg::WORD_WIDTH-1:0];
      rnd = $random(seed);
      beat.col1[l] = rnd[maxpool_pkg::WORD_WIDTH-1:0];
      if (negative) begin
        beat.col0[l][maxpool_pkg::WORD_WIDTH-1] = 1'b1;            // Force sign bit
        beat.col1[l][maxpool_pkg::WORD_WIDTH-1] = 1'b1;
      end
    end
  endtask

  // Holds the beat until accepted, s_ready read at the edge before update
  task automatic drive_beat(input maxpool_pkg::pool_beat_t beat,
                            input maxpool_pkg::pool_user_t user, input int gap);
    repeat (gap) begin
      s_valid <= 1'b0;
      @(posedge clk);
    end
    s_valid <= 1'b1;
    s_data  <= beat;
    s_user  <= user;
    @(posedge clk);
    while (!s_ready) @(posedge clk);
  endtask

  task automatic send_packet(input maxpool_pkg::pool_user_t user, input bit gaps,
                             input bit negative);
    maxpool_pkg::pool_beat_t beat;
    logic [31:0]             rnd;
    int                      gap;
    s_valid <= 1'b0;                                               // Old user spans the compare cycle
    @(posedge clk);
    for (int b = 0; b < PACKET_BEATS; b++) begin
      make_beat(negative, beat);
      rnd = $random(seed);
      gap = gaps ? int'(rnd % 3) : 0;                              // Zero to two idle cycles
      drive_beat(beat, user, gap);
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    s_valid <= 1'b0;
    @(negedge clk);
    while (exp_q.size() != 0 && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d expected output beats never appeared", exp_q.size()));
    end
    repeat (2) @(posedge clk);                                     // Let late assertion reports land
  endtask

  task automatic finish_test(input string name, input int errs_before);
    drain_outputs();
    test_num++;
    if (err_count == errs_before) begin
      tests_passed++;
      $display("Test %0d %s: passed", test_num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", test_num, name, err_count - errs_before);
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the engine stopped accepting or producing beats",
             cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int                      errs;
    logic [31:0]             rnd;
    maxpool_pkg::pool_user_t user;
    rst     = 1'b1;
    s_valid = 1'b0;
    s_data  = '0;
    s_user  = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    errs = err_count;
    send_packet(USER_BOTH, 1'b0, 1'b0);                            // First packet right after reset
    finish_test("after reset", errs);

    errs = err_count;
    repeat (2) send_packet(USER_NON_MAX, 1'b0, 1'b0);
    finish_test("non-max only", errs);

    errs = err_count;
    send_packet(USER_MAX, 1'b0, 1'b0);
    send_packet(USER_MAX, 1'b0, 1'b1);                             // All pixels negative
    finish_test("max only", errs);

    errs = err_count;
    send_packet(USER_MAX, 1'b0, 1'b0);                             // Valid held high through gaps
    send_packet(USER_BOTH, 1'b0, 1'b0);
    finish_test("s_ready compare gap", errs);

    errs = err_count;
    repeat (2) send_packet(USER_BOTH, 1'b0, 1'b0);
    finish_test("max and non-max", errs);

    errs = err_count;
    for (int p = 0; p < 8; p++) begin
      rnd = $random(seed);
      case (rnd % 3)
        0:       user = USER_NON_MAX;
        1:       user = USER_MAX;
        default: user = USER_BOTH;
      endcase
      send_packet(user, 1'b1, 1'b0);
    end
    finish_test("random s_valid gaps", errs);

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
